// ==== design/kmeans_collect_settings.svh ====
`ifndef KMEANS_COLLECT_SETTINGS_SVH
`define KMEANS_COLLECT_SETTINGS_SVH

// reducer bank layout
`define KM_REDUCERS        4
`define KM_CLUSTERS        6     // K
`define KM_DIMENSION       4     // coordinates per point
`define KM_BANK_ADDR_BITS  1     // enough for ceil(K / reducers) entries

// word widths
`define KM_SUM_WIDTH       32
`define KM_COUNT_WIDTH     32
`define KM_STREAM_WIDTH    32

// dimension * sum width / stream width
`define KM_BEATS_PER_SUM   4

`endif

// ==== design/kmeans_types_pkg.sv ====
`include "kmeans_collect_settings.svh"

package kmeans_types_pkg;

   ////////////////////////////////////////
   // data words seen at the reducer banks
   ////////////////////////////////////////

   // reducers fill coord, the sequencer walks beat
   typedef union packed
   {
      logic [`KM_DIMENSION-1:0][`KM_SUM_WIDTH-1:0]        coord;
      logic [`KM_BEATS_PER_SUM-1:0][`KM_STREAM_WIDTH-1:0] beat;
   } sum_vector_t;

   typedef logic [`KM_COUNT_WIDTH-1:0] count_t;      // points in one cluster

   typedef logic [`KM_STREAM_WIDTH-1:0] beat_t;      // one host stream word

   typedef logic [$clog2(`KM_CLUSTERS)-1:0] cluster_idx_t;

   typedef logic [`KM_BANK_ADDR_BITS-1:0] bank_addr_t;

endpackage

// ==== design/collect_ctrl_pkg.sv ====
package collect_ctrl_pkg;

   // which bank a read goes to
   typedef enum logic
   {
      READ_SUM   = 1'b0,
      READ_COUNT = 1'b1
   } read_kind_t;

   // sequencer run states, sums pass first then counts
   typedef enum logic [2:0]
   {
      IDLE,
      SUM_READ,
      SUM_WAIT,
      SUM_OUT,
      COUNT_READ,
      COUNT_WAIT,
      COUNT_OUT
   } collect_state_t;

endpackage

// ==== design/collect_ifs.sv ====
`timescale 1ns/1ns

////////////////////////////////////////
// bank read, sequencer to read port
////////////////////////////////////////

interface bank_read_if;
   import kmeans_types_pkg::*;
   import collect_ctrl_pkg::*;

   logic         rd_req;         // single cycle pulse
   read_kind_t   rd_kind;
   cluster_idx_t rd_cluster;
   logic         rd_valid;       // three cycles after rd_req
   sum_vector_t  rd_sum;         // held until the next rd_valid
   count_t       rd_count;

   modport requester (output rd_req, rd_kind, rd_cluster,
                      input  rd_valid, rd_sum, rd_count);

   modport responder (input  rd_req, rd_kind, rd_cluster,
                      output rd_valid, rd_sum, rd_count);
endinterface

////////////////////////////////////////
// beats, sequencer to stream stage
////////////////////////////////////////

interface beat_if;
   import kmeans_types_pkg::*;

   logic  beat_valid;
   beat_t beat_data;
   logic  beat_last;
   logic  beat_ready;

   modport source (output beat_valid, beat_data, beat_last, input beat_ready);

   modport sink (input beat_valid, beat_data, beat_last, output beat_ready);
endinterface

// ==== design/reducer_read_port.sv ====
`timescale 1ns/1ns
`include "kmeans_collect_settings.svh"

module reducer_read_port
(
   input  logic                          clock,
   input  logic                          reset_n,
   bank_read_if.responder                rd,
   output logic [`KM_REDUCERS-1:0]       o_ce_sums,
   output logic [`KM_REDUCERS-1:0]       o_ce_counters,
   output kmeans_types_pkg::bank_addr_t  o_bank_address,
   input  kmeans_types_pkg::sum_vector_t i_sum_pts [`KM_REDUCERS],
   input  kmeans_types_pkg::count_t      i_count_pts [`KM_REDUCERS]
);
   import kmeans_types_pkg::*;
   import collect_ctrl_pkg::*;

   typedef logic [`KM_REDUCERS-1:0] ce_vec_t;

   ce_vec_t     reducer_bit;     // cluster mod reducers, one hot
   bank_addr_t  bank_addr;
   ce_vec_t     sel_sum;         // enables delayed to the return cycle
   ce_vec_t     sel_count;
   sum_vector_t sum_mux;
   count_t      count_mux;
   sum_vector_t sum_q;
   count_t      count_q;
   logic        valid_q;

   assign reducer_bit = ce_vec_t'(1) << (rd.rd_cluster % `KM_REDUCERS);
   assign bank_addr   = bank_addr_t'(rd.rd_cluster / `KM_REDUCERS);

   // enables and address, one cycle after the request
   always_ff @(posedge clock)
   begin
      if (!reset_n)
      begin
         o_ce_sums      <= '0;
         o_ce_counters  <= '0;
         o_bank_address <= '0;
         sel_sum        <= '0;
         sel_count      <= '0;
         valid_q        <= 1'b0;
      end
      else
      begin
         o_ce_sums     <= (rd.rd_req && rd.rd_kind == READ_SUM) ? reducer_bit : '0;
         o_ce_counters <= (rd.rd_req && rd.rd_kind == READ_COUNT) ? reducer_bit : '0;
         if (rd.rd_req)
            o_bank_address <= bank_addr;
         sel_sum   <= o_ce_sums;       // bank word shows up now
         sel_count <= o_ce_counters;
         valid_q   <= (|sel_sum) || (|sel_count);
      end
   end

   ////////////////////////////////////////
   // reducer mux and holding registers
   ////////////////////////////////////////

   always_comb
   begin
      sum_mux   = '0;
      count_mux = '0;
      for (int i = 0; i < `KM_REDUCERS; i++)
      begin
         if (sel_sum[i])
            sum_mux = i_sum_pts[i];
         if (sel_count[i])
            count_mux = i_count_pts[i];
      end
   end

   always_ff @(posedge clock)
   begin
      if (|sel_sum)
         sum_q <= sum_mux;
      if (|sel_count)
         count_q <= count_mux;
   end

   assign rd.rd_valid = valid_q;
   assign rd.rd_sum   = sum_q;
   assign rd.rd_count = count_q;

endmodule

// ==== design/collect_sequencer.sv ====
`timescale 1ns/1ns
`include "kmeans_collect_settings.svh"

module collect_sequencer
(
   input  logic           clock,
   input  logic           reset_n,
   input  logic           i_start,
   output logic           o_done,
   bank_read_if.requester rd,
   beat_if.source         beat
);
   import kmeans_types_pkg::*;
   import collect_ctrl_pkg::*;

   typedef logic [$clog2(`KM_BEATS_PER_SUM)-1:0] beat_idx_t;

   localparam beat_idx_t    LAST_BEAT    = beat_idx_t'(`KM_BEATS_PER_SUM - 1);
   localparam cluster_idx_t LAST_CLUSTER = cluster_idx_t'(`KM_CLUSTERS - 1);

   collect_state_t state;
   cluster_idx_t   cluster;
   beat_idx_t      beat_cnt;     // coordinate beat inside a sum vector
   logic           done_q;
   logic           xfer;

   ////////////////////////////////////////
   // read requests
   ////////////////////////////////////////

   assign rd.rd_req     = (state == SUM_READ) || (state == COUNT_READ);
   assign rd.rd_kind    = (state == COUNT_READ) ? READ_COUNT : READ_SUM;
   assign rd.rd_cluster = cluster;

   ////////////////////////////////////////
   // beat offer
   ////////////////////////////////////////

   assign beat.beat_valid = (state == SUM_OUT) || (state == COUNT_OUT);
   assign beat.beat_data  = (state == COUNT_OUT) ? beat_t'(rd.rd_count)
                                                 : rd.rd_sum.beat[beat_cnt];
   assign beat.beat_last  = (state == COUNT_OUT) && (cluster == LAST_CLUSTER);
   assign xfer            = beat.beat_valid && beat.beat_ready;

   always_ff @(posedge clock)
   begin
      if (!reset_n)
      begin
         state    <= IDLE;
         cluster  <= '0;
         beat_cnt <= '0;
         done_q   <= 1'b0;
      end
      else
      begin
         done_q <= xfer && beat.beat_last;
         case (state)
            IDLE:
            begin
               cluster  <= '0;
               beat_cnt <= '0;
               if (i_start)
                  state <= SUM_READ;
            end
            SUM_READ:
               state <= SUM_WAIT;
            SUM_WAIT:
               if (rd.rd_valid)
                  state <= SUM_OUT;
            SUM_OUT:
            begin
               if (xfer)
               begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (beat_cnt == LAST_BEAT)
                  begin
                     beat_cnt <= '0;
                     if (cluster == LAST_CLUSTER)
                     begin
                        cluster <= '0;         // second walk, counts
                        state   <= COUNT_READ;
                     end
                     else
                     begin
                        cluster <= cluster + 1'b1;
                        state   <= SUM_READ;
                     end
                  end
               end
            end
            COUNT_READ:
               state <= COUNT_WAIT;
            COUNT_WAIT:
               if (rd.rd_valid)
                  state <= COUNT_OUT;
            COUNT_OUT:
            begin
               if (xfer)
               begin
                  if (cluster == LAST_CLUSTER)
                     state <= IDLE;
                  else
                  begin
                     cluster <= cluster + 1'b1;
                     state   <= COUNT_READ;
                  end
               end
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   assign o_done = done_q;    // cycle after the tlast beat moves on

endmodule

// ==== design/stream_output.sv ====
`timescale 1ns/1ns

module stream_output
(
   input  logic                    clock,
   input  logic                    reset_n,
   beat_if.sink                    beat,
   output kmeans_types_pkg::beat_t o_tdata,
   output logic                    o_tvalid,
   output logic                    o_tlast,
   input  logic                    i_tready
);

   // one entry, room when empty or draining this cycle
   assign beat.beat_ready = !o_tvalid || i_tready;

   always_ff @(posedge clock)
   begin
      if (!reset_n)
      begin
         o_tvalid <= 1'b0;
         o_tlast  <= 1'b0;
      end
      else if (beat.beat_ready)
      begin
         o_tvalid <= beat.beat_valid;    // drops when drained with nothing behind
         o_tlast  <= beat.beat_valid && beat.beat_last;
      end
   end

   // payload only
   always_ff @(posedge clock)
   begin
      if (beat.beat_ready && beat.beat_valid)
         o_tdata <= beat.beat_data;
   end

endmodule

// ==== design/kmeans_collect_top.sv ====
`timescale 1ns/1ns
`include "kmeans_collect_settings.svh"

module kmeans_collect_top
(
   input  logic                          clock,
   input  logic                          reset_n,
   input  logic                          i_start,
   output logic                          o_done,

   // reducer banks
   output logic [`KM_REDUCERS-1:0]       o_ce_sums,
   output logic [`KM_REDUCERS-1:0]       o_ce_counters,
   output kmeans_types_pkg::bank_addr_t  o_bank_address,
   input  kmeans_types_pkg::sum_vector_t i_sum_pts [`KM_REDUCERS],
   input  kmeans_types_pkg::count_t      i_count_pts [`KM_REDUCERS],

   // host stream
   output kmeans_types_pkg::beat_t       o_tdata,
   output logic                          o_tvalid,
   output logic                          o_tlast,
   input  logic                          i_tready
);

   bank_read_if u_rd_if ();
   beat_if      u_beat_if ();

   reducer_read_port u_reducer_read_port
   (
      .clock          (clock),
      .reset_n        (reset_n),
      .rd             (u_rd_if.responder),
      .o_ce_sums      (o_ce_sums),
      .o_ce_counters  (o_ce_counters),
      .o_bank_address (o_bank_address),
      .i_sum_pts      (i_sum_pts),
      .i_count_pts    (i_count_pts)
   );

   collect_sequencer u_collect_sequencer
   (
      .clock   (clock),
      .reset_n (reset_n),
      .i_start (i_start),
      .o_done  (o_done),
      .rd      (u_rd_if.requester),
      .beat    (u_beat_if.source)
   );

   stream_output u_stream_output
   (
      .clock    (clock),
      .reset_n  (reset_n),
      .beat     (u_beat_if.sink),
      .o_tdata  (o_tdata),
      .o_tvalid (o_tvalid),
      .o_tlast  (o_tlast),
      .i_tready (i_tready)
   );

endmodule

// ==== testbench/kmeans_collect_asserts.sv ====
`timescale 1ns/1ns
`include "kmeans_collect_settings.svh"

module kmeans_collect_asserts
(
   input logic                    clock,
   input logic                    reset_n,
   input logic [`KM_REDUCERS-1:0] o_ce_sums,
   input logic [`KM_REDUCERS-1:0] o_ce_counters,
   input kmeans_types_pkg::beat_t o_tdata,
   input logic                    o_tvalid,
   input logic                    i_tready,
   input logic                    o_done
);

   int fail_count = 0;    // assertion failures so far

   // held beat stays put until the host takes it
   stream_hold: assert property (@(posedge clock) disable iff (!reset_n)
      o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata))
      else
      begin
         $error("stream beat changed while stalled");
         fail_count++;
      end

   one_enable: assert property (@(posedge clock) disable iff (!reset_n)
      $onehot0({o_ce_sums, o_ce_counters}))
      else
      begin
         $error("more than one bank enable high");
         fail_count++;
      end

   done_pulse: assert property (@(posedge clock) disable iff (!reset_n)
      o_done |=> !o_done)
      else
      begin
         $error("o_done longer than one cycle");
         fail_count++;
      end

endmodule

bind kmeans_collect_top kmeans_collect_asserts u_kmeans_collect_asserts
(
   .clock         (clock),
   .reset_n       (reset_n),
   .o_ce_sums     (o_ce_sums),
   .o_ce_counters (o_ce_counters),
   .o_tdata       (o_tdata),
   .o_tvalid      (o_tvalid),
   .i_tready      (i_tready),
   .o_done        (o_done)
);

// ==== testbench/kmeans_collect_tb.sv ====
`timescale 1ns/1ns
`include "kmeans_collect_settings.svh"

module kmeans_collect_tb;
   import kmeans_types_pkg::*;

   localparam int CLOCK_PERIOD = 40;
   localparam int R            = `KM_REDUCERS;
   localparam int SUM_BEATS    = `KM_CLUSTERS * `KM_BEATS_PER_SUM;
   localparam int TOTAL_BEATS  = SUM_BEATS + `KM_CLUSTERS;     // 30
   localparam int TOTAL_READS  = 2 * `KM_CLUSTERS;
   localparam int RUNS         = 5;
   localparam int RUN_CYCLES   = 12 * 6 + 30 * 8;             // reads plus beats, worst case

   logic        clock, reset_n, i_start, o_done, o_tvalid, o_tlast, i_tready;
   logic [R-1:0] o_ce_sums, o_ce_counters;
   bank_addr_t  o_bank_address;
   sum_vector_t i_sum_pts [R];
   count_t      i_count_pts [R];
   beat_t       o_tdata;

   sum_vector_t sum_mem [R][1 << `KM_BANK_ADDR_BITS];   // reducer bank contents
   count_t      count_mem [R][1 << `KM_BANK_ADDR_BITS];
   logic [15:0] lfsr_q = 16'd68;
   bit          bp_on = 0;
   int          beat_idx, read_idx, done_count, checks, errors;
   bit          last_accepted;

   kmeans_collect_top u_kmeans_collect_top (.*);

   always #(CLOCK_PERIOD / 2) clock = ~clock;

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////

   // x^16 + x^14 + x^13 + x^11, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
         v = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // {tlast, tdata} of beat n, sums cluster by cluster then counts
   function automatic logic [32:0] expected_beat(input int n);
      int c;
      beat_t d;
      if (n < SUM_BEATS)
      begin
         c = n / `KM_BEATS_PER_SUM;
         d = sum_mem[c % R][c / R].coord[n % `KM_BEATS_PER_SUM];
      end
      else
      begin
         c = n - SUM_BEATS;
         d = count_mem[c % R][c / R];
      end
      return {n == TOTAL_BEATS - 1, d};
   endfunction

   // {sum enables, count enables, address} of read n
   function automatic logic [2*R:0] expected_read(input int n);
      int c;
      logic [R-1:0] hot;
      c = n % `KM_CLUSTERS;
      hot = '0;
      hot[c % R] = 1'b1;
      return (n < `KM_CLUSTERS) ? {hot, {R{1'b0}}, 1'(c / R)} : {{R{1'b0}}, hot, 1'(c / R)};
   endfunction

   // value mismatches plus bound assertion failures
   function automatic int failures();
      return errors + u_kmeans_collect_top.u_kmeans_collect_asserts.fail_count;
   endfunction

   task automatic check_value(input logic [63:0] actual, expected, input string what);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("ERROR %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic fill_banks();
      for (int r = 0; r < R; r++)
         for (int a = 0; a < (1 << `KM_BANK_ADDR_BITS); a++)
         begin
            for (int d = 0; d < `KM_DIMENSION; d++)
               sum_mem[r][a].coord[d] = take_bits(32);
            count_mem[r][a] = take_bits(16);
         end
   endtask

   task automatic start_run(input bit with_bp);
      fill_banks();
      beat_idx = 0;
      read_idx = 0;
      done_count = 0;
      last_accepted = 0;
      @(posedge clock);
      bp_on = with_bp;
      #2 i_start = 1'b1;
      @(posedge clock);
      #2 i_start = 1'b0;
   endtask

   task automatic finish_run();
      wait (last_accepted && done_count != 0);
      repeat (4) @(posedge clock);    // room for a stray second pulse
      bp_on = 0;
      check_value(beat_idx, TOTAL_BEATS, "accepted beats");
      check_value(read_idx, TOTAL_READS, "bank reads");
      check_value(done_count, 1, "done pulses");
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      $display("test %0d %-26s %s", num, name, (failures() == errs_before) ? "ok" : "failed");
   endtask

   ////////////////////////////////////////
   // bank model, host side ready, monitor
   ////////////////////////////////////////

   always @(posedge clock)
   begin : bank_model
      logic [R-1:0] ce_s, ce_c;
      bank_addr_t   addr;
      ce_s = o_ce_sums;
      ce_c = o_ce_counters;
      addr = o_bank_address;
      if (reset_n && (|{ce_s, ce_c}))
      begin
         if (read_idx < TOTAL_READS)
            check_value({ce_s, ce_c, addr}, expected_read(read_idx),
                        $sformatf("read %0d enables", read_idx));
         else
         begin
            errors++;
            $display("a bank was read again after all clusters were read");
         end
         read_idx++;
      end
      #2;
      for (int r = 0; r < R; r++)
      begin
         if (ce_s[r])
            i_sum_pts[r] = sum_mem[r][addr];
         if (ce_c[r])
            i_count_pts[r] = count_mem[r][addr];
      end
   end

   always @(posedge clock)
   begin
      #2 i_tready = bp_on ? 1'(take_bits(1)) : 1'b1;
   end

   always @(posedge clock)
   begin
      if (reset_n && o_tvalid && i_tready)
      begin
         if (beat_idx < TOTAL_BEATS)
            check_value({o_tlast, o_tdata}, expected_beat(beat_idx),
                        $sformatf("beat %0d", beat_idx));
         else
         begin
            errors++;
            $display("a beat came out after the tlast beat");
         end
         beat_idx++;
         if (o_tlast)
            last_accepted = 1;
      end
      if (reset_n && o_done)
      begin
         done_count++;
         check_value(o_tvalid && o_tlast, 1, "tlast beat present at o_done");
      end
   end

   initial
   begin
      #(RUNS * RUN_CYCLES * CLOCK_PERIOD);
      $display("timeout: the readout never finished within the time limit");
      $display("*** TEST FAILED ***");
      $finish;
   end

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////

   initial
   begin : tests
      int errs;
      clock = 0;
      reset_n = 0;
      i_start = 0;
      i_tready = 1;
      for (int r = 0; r < R; r++)
      begin
         i_sum_pts[r] = '0;
         i_count_pts[r] = '0;
      end
      repeat (16) @(posedge clock);
      #2 reset_n = 1;

      errs = failures();
      start_run(0);
      finish_run();
      report_test(1, "full readout", errs);

      errs = failures();
      start_run(1);
      finish_run();
      report_test(2, "random back-pressure", errs);

      errs = failures();
      start_run(1);
      wait (beat_idx >= 5);
      #2 i_start = 1'b1;         // must be ignored mid run
      @(posedge clock);
      #2 i_start = 1'b0;
      finish_run();
      report_test(3, "start pulse during run", errs);

      errs = failures();
      start_run(0);
      wait (beat_idx >= 10);
      #2 reset_n = 0;
      repeat (2) @(posedge clock);
      check_value({o_tvalid, o_tlast, o_done, o_ce_sums, o_ce_counters}, '0,
                  "outputs in reset");
      repeat (2) @(posedge clock);
      #2 reset_n = 1;
      start_run(0);
      finish_run();
      report_test(4, "reset mid run then rerun", errs);

      $display("tests 4, checks %0d, errors %0d", checks, failures());
      if (failures() == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== kmeans_collect.f ====
+incdir+design
design/kmeans_types_pkg.sv
design/collect_ctrl_pkg.sv
design/collect_ifs.sv
design/reducer_read_port.sv
design/collect_sequencer.sv
design/stream_output.sv
design/kmeans_collect_top.sv
testbench/kmeans_collect_asserts.sv
testbench/kmeans_collect_tb.sv

// ==== Bender.yml ====
package:
  name: kmeans_collect

sources:
  - include_dirs:
      - design
    files:
      - design/kmeans_types_pkg.sv
      - design/collect_ctrl_pkg.sv
      - design/collect_ifs.sv
      - design/reducer_read_port.sv
      - design/collect_sequencer.sv
      - design/stream_output.sv
      - design/kmeans_collect_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/kmeans_collect_asserts.sv
      - testbench/kmeans_collect_tb.sv
